/* hw/core_pkg.sv */
`default_nettype none

package core_pkg;

    parameter int XLEN  = 32;
    parameter int LANES = 2;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LUI     = 6'h0f;

    // funct field of SPECIAL
    localparam logic [5:0] FN_MFHI  = 6'h10;
    localparam logic [5:0] FN_MTHI  = 6'h11;
    localparam logic [5:0] FN_MFLO  = 6'h12;
    localparam logic [5:0] FN_MTLO  = 6'h13;
    localparam logic [5:0] FN_MULTU = 6'h19;
    localparam logic [5:0] FN_ADDU  = 6'h21;
    localparam logic [5:0] FN_SUBU  = 6'h23;
    localparam logic [5:0] FN_AND   = 6'h24;
    localparam logic [5:0] FN_OR    = 6'h25;
    localparam logic [5:0] FN_XOR   = 6'h26;

    typedef enum logic [3:0] {
        OP_NOP, OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_ADDIU,
        OP_ORI, OP_LUI, OP_MULTU, OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO
    } op_t;

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_type_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_type_t;

    // same word, two field layouts
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        word_t adr;
    } wb_req_t;

    // instr[0] is the older word at pc
    typedef struct packed {
        logic             valid;
        word_t            pc;
        instr_u [1:0]     instr;
    } bundle_t;

    typedef struct packed {
        logic      valid;
        op_t       op;
        reg_addr_t rd;
        logic      writes_gpr;
        word_t     a;
        word_t     b;
    } lane_op_t;

    typedef struct packed {
        logic              valid;
        op_t               op;
        reg_addr_t         rd;
        logic              writes_gpr;
        word_t             result;
        logic [2*XLEN-1:0] product;
        logic              hi_we;
        logic              lo_we;
    } lane_res_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } commit_t;

endpackage

`default_nettype wire

/* hw/fetch_unit.sv */
`default_nettype none

module fetch_unit
    import core_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  wire              clk,
    input  wire              reset,
    input  wire [2*XLEN-1:0] i_wb_dat,
    input  wire              i_wb_ack,
    input  wire              i_take,
    output wb_req_t          o_wb,
    output bundle_t          o_bundle
);

    word_t pc_q;
    logic  active_q;
    logic  req;
    logic  ack_fire;

    // request whenever the buffer is free or being emptied right now
    assign req      = active_q && (!o_bundle.valid || i_take);
    assign ack_fire = req && i_wb_ack;

    always_comb begin
        o_wb.cyc = req;
        o_wb.stb = req;
        o_wb.adr = pc_q;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_q       <= 1'b0;
            pc_q           <= RESET_PC;
            o_bundle.valid <= 1'b0;
        end else begin
            // first request goes out one cycle after reset drops
            active_q <= 1'b1;
            if (ack_fire) begin
                pc_q              <= pc_q + word_t'(8);
                o_bundle.valid    <= 1'b1;
                o_bundle.pc       <= pc_q;
                // low word is the older instruction
                o_bundle.instr[0] <= i_wb_dat[XLEN-1:0];
                o_bundle.instr[1] <= i_wb_dat[2*XLEN-1:XLEN];
            end else if (i_take) begin
                o_bundle.valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/issue_unit.sv */
`default_nettype none

module issue_unit
    import core_pkg::*;
(
    input  wire                          clk,
    input  wire                          reset,
    input  wire bundle_t                 i_bundle,
    input  wire lane_res_t [LANES-1:0]   i_res,
    input  wire word_t                   i_hi,
    input  wire word_t                   i_lo,
    input  wire word_t [3:0]             i_rdata,
    output logic                         o_take,
    output reg_addr_t [3:0]              o_raddr,
    output lane_op_t [LANES-1:0]         o_lane_op
);

    typedef struct packed {
        op_t       op;
        reg_addr_t rd;
        logic      writes_gpr;
        logic      reads_rs;
        logic      reads_rt;
        logic      reads_hi;
        logic      reads_lo;
        logic      writes_hi;
        logic      writes_lo;
    } dec_t;

    function automatic dec_t decode(instr_u w);
        dec_t d;
        d = '0;
        if (w.r.opcode == OPC_SPECIAL) begin
            case (w.r.funct)
                FN_ADDU:  d.op = OP_ADDU;
                FN_SUBU:  d.op = OP_SUBU;
                FN_AND:   d.op = OP_AND;
                FN_OR:    d.op = OP_OR;
                FN_XOR:   d.op = OP_XOR;
                FN_MULTU: d.op = OP_MULTU;
                FN_MFHI:  d.op = OP_MFHI;
                FN_MFLO:  d.op = OP_MFLO;
                FN_MTHI:  d.op = OP_MTHI;
                FN_MTLO:  d.op = OP_MTLO;
                default:  d.op = OP_NOP;
            endcase
            d.rd = w.r.rd;
        end else begin
            case (w.i.opcode)
                OPC_ADDIU: d.op = OP_ADDIU;
                OPC_ORI:   d.op = OP_ORI;
                OPC_LUI:   d.op = OP_LUI;
                default:   d.op = OP_NOP;
            endcase
            d.rd = w.i.rt;
        end
        d.writes_gpr = d.op inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR,
                                    OP_ADDIU, OP_ORI, OP_LUI, OP_MFHI, OP_MFLO};
        d.reads_rs   = d.op inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR,
                                    OP_ADDIU, OP_ORI, OP_MULTU, OP_MTHI, OP_MTLO};
        d.reads_rt   = d.op inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_MULTU};
        d.reads_hi   = d.op == OP_MFHI;
        d.reads_lo   = d.op == OP_MFLO;
        d.writes_hi  = d.op inside {OP_MULTU, OP_MTHI};
        d.writes_lo  = d.op inside {OP_MULTU, OP_MTLO};
        return d;
    endfunction

    // lane 1 is younger, so it is checked last and wins
    function automatic word_t fwd_gpr(reg_addr_t addr, word_t rf_val,
                                      lane_res_t [LANES-1:0] res);
        word_t v;
        v = rf_val;
        for (int l = 0; l < LANES; l++) begin
            if (res[l].valid && res[l].writes_gpr && res[l].rd == addr && addr != '0) begin
                v = res[l].result;
            end
        end
        return v;
    endfunction

    dec_t [LANES-1:0] dec;
    logic [LANES-1:0] go;
    logic             first_done_q;
    logic             gpr_dep;
    logic             hilo_dep;
    logic             split;
    word_t            hi_fwd;
    word_t            lo_fwd;

    always_comb begin
        for (int s = 0; s < LANES; s++) begin
            dec[s]           = decode(i_bundle.instr[s]);
            o_raddr[2*s]     = i_bundle.instr[s].r.rs;
            o_raddr[2*s + 1] = i_bundle.instr[s].r.rt;
        end
    end

    // younger word waits if it reads what the older one writes
    assign gpr_dep  = dec[0].writes_gpr && dec[0].rd != '0 &&
                      ((dec[1].reads_rs && i_bundle.instr[1].r.rs == dec[0].rd) ||
                       (dec[1].reads_rt && i_bundle.instr[1].r.rt == dec[0].rd));
    assign hilo_dep = (dec[1].reads_hi && dec[0].writes_hi) ||
                      (dec[1].reads_lo && dec[0].writes_lo);
    assign split    = gpr_dep || hilo_dep;

    assign go[0]  = !first_done_q;
    assign go[1]  = first_done_q || !split;
    assign o_take = i_bundle.valid && go[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            first_done_q <= 1'b0;
        end else if (i_bundle.valid && !first_done_q && split) begin
            first_done_q <= 1'b1;
        end else if (o_take) begin
            first_done_q <= 1'b0;
        end
    end

    always_comb begin
        hi_fwd = i_hi;
        lo_fwd = i_lo;
        for (int l = 0; l < LANES; l++) begin
            if (i_res[l].valid && i_res[l].hi_we) begin
                hi_fwd = i_res[l].product[2*XLEN-1:XLEN];
            end
            if (i_res[l].valid && i_res[l].lo_we) begin
                lo_fwd = i_res[l].product[XLEN-1:0];
            end
        end
    end

    always_comb begin
        word_t       rt_val;
        logic [15:0] imm;
        for (int s = 0; s < LANES; s++) begin
            imm    = i_bundle.instr[s].i.imm;
            rt_val = fwd_gpr(o_raddr[2*s + 1], i_rdata[2*s + 1], i_res);
            o_lane_op[s].valid      = i_bundle.valid && go[s];
            o_lane_op[s].op         = dec[s].op;
            o_lane_op[s].rd         = dec[s].rd;
            o_lane_op[s].writes_gpr = dec[s].writes_gpr;
            o_lane_op[s].a          = fwd_gpr(o_raddr[2*s], i_rdata[2*s], i_res);
            if (dec[s].reads_hi) begin
                o_lane_op[s].a = hi_fwd;
            end else if (dec[s].reads_lo) begin
                o_lane_op[s].a = lo_fwd;
            end
            case (dec[s].op)
                OP_ADDIU: o_lane_op[s].b = {{16{imm[15]}}, imm};
                OP_ORI:   o_lane_op[s].b = {16'h0000, imm};
                OP_LUI:   o_lane_op[s].b = {imm, 16'h0000};
                default:  o_lane_op[s].b = rt_val;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`default_nettype none

module reg_file
    import core_pkg::*;
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire reg_addr_t [3:0]       i_raddr,
    input  wire [LANES-1:0]            i_we,
    input  wire reg_addr_t [LANES-1:0] i_waddr,
    input  wire word_t [LANES-1:0]     i_wdata,
    output word_t [3:0]                o_rdata
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // higher port is the younger lane and lands last
            for (int p = 0; p < LANES; p++) begin
                if (i_we[p]) begin
                    regs[i_waddr[p]] <= i_wdata[p];
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            o_rdata[k] = (i_raddr[k] == '0) ? '0 : regs[i_raddr[k]];
        end
    end

endmodule

`default_nettype wire

/* hw/exec_lane.sv */
`default_nettype none

module exec_lane
    import core_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire lane_op_t i_op,
    output lane_res_t     o_res
);

    word_t             result;
    logic [2*XLEN-1:0] product;
    logic              hi_we;
    logic              lo_we;

    always_comb begin
        case (i_op.op)
            OP_ADDU, OP_ADDIU: result = i_op.a + i_op.b;
            OP_SUBU:           result = i_op.a - i_op.b;
            OP_AND:            result = i_op.a & i_op.b;
            OP_OR, OP_ORI:     result = i_op.a | i_op.b;
            OP_XOR:            result = i_op.a ^ i_op.b;
            OP_LUI:            result = i_op.b;
            // issue already placed hi or lo on operand a
            OP_MFHI, OP_MFLO:  result = i_op.a;
            default:           result = '0;
        endcase
    end

    // hi in the upper half, lo in the lower half
    always_comb begin
        case (i_op.op)
            OP_MULTU: product = (2*XLEN)'(i_op.a) * (2*XLEN)'(i_op.b);
            OP_MTHI:  product = {i_op.a, word_t'(0)};
            OP_MTLO:  product = {word_t'(0), i_op.a};
            default:  product = '0;
        endcase
    end

    assign hi_we = i_op.valid && (i_op.op inside {OP_MULTU, OP_MTHI});
    assign lo_we = i_op.valid && (i_op.op inside {OP_MULTU, OP_MTLO});

    always_ff @(posedge clk) begin
        if (reset) begin
            o_res.valid <= 1'b0;
        end else begin
            o_res.valid <= i_op.valid;
        end
        o_res.op         <= i_op.op;
        o_res.rd         <= i_op.rd;
        o_res.writes_gpr <= i_op.writes_gpr;
        o_res.result     <= result;
        o_res.product    <= product;
        o_res.hi_we      <= hi_we;
        o_res.lo_we      <= lo_we;
    end

endmodule

`default_nettype wire

/* hw/retire_unit.sv */
`default_nettype none

module retire_unit
    import core_pkg::*;
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire lane_res_t [LANES-1:0] i_res,
    output logic [LANES-1:0]           o_we,
    output reg_addr_t [LANES-1:0]      o_waddr,
    output word_t [LANES-1:0]          o_wdata,
    output word_t                      o_hi,
    output word_t                      o_lo,
    output commit_t [LANES-1:0]        o_commit
);

    // writes to r0 vanish here and never show as commits
    always_comb begin
        logic we;
        for (int l = 0; l < LANES; l++) begin
            we = i_res[l].valid && i_res[l].writes_gpr && i_res[l].rd != '0;
            o_we[l]           = we;
            o_waddr[l]        = i_res[l].rd;
            o_wdata[l]        = i_res[l].result;
            o_commit[l].valid = we;
            o_commit[l].rd    = i_res[l].rd;
            o_commit[l].data  = i_res[l].result;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_hi <= '0;
            o_lo <= '0;
        end else begin
            // later lane overrides the earlier one
            for (int l = 0; l < LANES; l++) begin
                if (i_res[l].valid && i_res[l].hi_we) begin
                    o_hi <= i_res[l].product[2*XLEN-1:XLEN];
                end
                if (i_res[l].valid && i_res[l].lo_we) begin
                    o_lo <= i_res[l].product[XLEN-1:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/dual_issue_core.sv */
`default_nettype none

module dual_issue_core
    import core_pkg::*;
#(
    parameter word_t RESET_PC = '0
) (
    input  wire                 clk,
    input  wire                 reset,
    input  wire [2*XLEN-1:0]    i_wb_dat,
    input  wire                 i_wb_ack,
    output wb_req_t             o_wb,
    output commit_t [LANES-1:0] o_commit
);

    bundle_t                bundle;
    logic                   take;
    lane_op_t [LANES-1:0]   lane_op;
    lane_res_t [LANES-1:0]  lane_res;
    reg_addr_t [3:0]        raddr;
    word_t [3:0]            rdata;
    logic [LANES-1:0]       we;
    reg_addr_t [LANES-1:0]  waddr;
    word_t [LANES-1:0]      wdata;
    word_t                  hi;
    word_t                  lo;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk, .reset, .i_wb_dat, .i_wb_ack,
        .i_take   (take),
        .o_wb,
        .o_bundle (bundle)
    );

    issue_unit u_issue (
        .clk, .reset,
        .i_bundle  (bundle),
        .i_res     (lane_res),
        .i_hi      (hi),
        .i_lo      (lo),
        .i_rdata   (rdata),
        .o_take    (take),
        .o_raddr   (raddr),
        .o_lane_op (lane_op)
    );

    reg_file u_regs (
        .clk, .reset,
        .i_raddr (raddr),
        .i_we    (we),
        .i_waddr (waddr),
        .i_wdata (wdata),
        .o_rdata (rdata)
    );

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        exec_lane u_lane (
            .clk, .reset,
            .i_op  (lane_op[l]),
            .o_res (lane_res[l])
        );
    end

    retire_unit u_retire (
        .clk, .reset,
        .i_res   (lane_res),
        .o_we    (we),
        .o_waddr (waddr),
        .o_wdata (wdata),
        .o_hi    (hi),
        .o_lo    (lo),
        .o_commit
    );

endmodule

`default_nettype wire

/* test/tb_core.sv */
`default_nettype none

module tb_core
    import core_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NPAIRS = 64;
    localparam int NDIRECTED = 18;

    typedef struct {
        op_t         op;
        reg_addr_t   rd;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } ins_t;

    typedef commit_t commit_q_t[$];

    logic                clk;
    logic                reset;
    logic [2*XLEN-1:0]   wb_dat = '0;
    logic                wb_ack = 1'b0;
    wb_req_t             wb;
    commit_t [LANES-1:0] commit;

    ins_t              prog [2*NPAIRS];
    logic [2*XLEN-1:0] mem [NPAIRS];
    commit_q_t         exp_q;
    logic [31:0]       rng_state = 32'd49;
    int                got = 0;
    int                errors = 0;
    word_t             next_adr = '0;
    logic              armed = 1'b0;
    int                delay_left = 0;

    dual_issue_core #(
        .RESET_PC (32'h0000_0000)
    ) i_dut (
        .clk      (clk),
        .reset    (reset),
        .i_wb_dat (wb_dat),
        .i_wb_ack (wb_ack),
        .o_wb     (wb),
        .o_commit (commit)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int unsigned rand_below(int unsigned n);
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return (rng_state >> 16) % n;
    endfunction

    function automatic ins_t make_ins(op_t op, int rd, int rs, int rt, int imm);
        ins_t x;
        x.op  = op;
        x.rd  = reg_addr_t'(rd);
        x.rs  = reg_addr_t'(rs);
        x.rt  = reg_addr_t'(rt);
        x.imm = 16'(imm);
        return x;
    endfunction

    function automatic word_t encode(ins_t x);
        instr_u w;
        w = '0;
        case (x.op)
            OP_ADDIU, OP_ORI, OP_LUI: begin
                w.i.opcode = (x.op == OP_ADDIU) ? OPC_ADDIU :
                             (x.op == OP_ORI) ? OPC_ORI : OPC_LUI;
                w.i.rs     = (x.op == OP_LUI) ? 5'd0 : x.rs;
                w.i.rt     = x.rd;
                w.i.imm    = x.imm;
            end
            // invalid word with either a bad opcode or a bad funct
            OP_NOP: begin
                w.i.opcode = x.imm[0] ? 6'h3f : OPC_SPECIAL;
                w.i.rs     = x.rs;
                w.i.rt     = x.rd;
                w.i.imm    = {x.imm[15:6], 6'h3f};
            end
            default: begin
                w.r.opcode = OPC_SPECIAL;
                w.r.rs = (x.op inside {OP_MFHI, OP_MFLO}) ? 5'd0 : x.rs;
                w.r.rt = (x.op inside {OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO}) ? 5'd0 : x.rt;
                w.r.rd = (x.op inside {OP_MULTU, OP_MTHI, OP_MTLO}) ? 5'd0 : x.rd;
                case (x.op)
                    OP_ADDU:  w.r.funct = FN_ADDU;
                    OP_SUBU:  w.r.funct = FN_SUBU;
                    OP_AND:   w.r.funct = FN_AND;
                    OP_OR:    w.r.funct = FN_OR;
                    OP_XOR:   w.r.funct = FN_XOR;
                    OP_MULTU: w.r.funct = FN_MULTU;
                    OP_MFHI:  w.r.funct = FN_MFHI;
                    OP_MFLO:  w.r.funct = FN_MFLO;
                    OP_MTHI:  w.r.funct = FN_MTHI;
                    default:  w.r.funct = FN_MTLO;
                endcase
            end
        endcase
        return w;
    endfunction

    // in-order model of the program that yields one commit per real register write
    function automatic commit_q_t run_reference();
        commit_q_t   q;
        word_t       regs [32];
        word_t       hi;
        word_t       lo;
        word_t       a;
        word_t       b;
        word_t       val;
        logic [15:0] imm;
        logic [63:0] prod;
        logic        wr;
        commit_t     c;
        hi = '0;
        lo = '0;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int n = 0; n < 2*NPAIRS; n++) begin
            a   = regs[prog[n].rs];
            b   = regs[prog[n].rt];
            imm = prog[n].imm;
            wr  = 1'b1;
            val = '0;
            case (prog[n].op)
                OP_ADDU:  val = a + b;
                OP_SUBU:  val = a - b;
                OP_AND:   val = a & b;
                OP_OR:    val = a | b;
                OP_XOR:   val = a ^ b;
                OP_ADDIU: val = a + {{16{imm[15]}}, imm};
                OP_ORI:   val = a | {16'h0000, imm};
                OP_LUI:   val = {imm, 16'h0000};
                OP_MFHI:  val = hi;
                OP_MFLO:  val = lo;
                OP_MULTU: begin
                    prod = 64'(a) * 64'(b);
                    hi   = prod[63:32];
                    lo   = prod[31:0];
                    wr   = 1'b0;
                end
                OP_MTHI: begin
                    hi = a;
                    wr = 1'b0;
                end
                OP_MTLO: begin
                    lo = a;
                    wr = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            // r0 is never written
            if (wr && prog[n].rd != 5'd0) begin
                regs[prog[n].rd] = val;
                c.valid = 1'b1;
                c.rd    = prog[n].rd;
                c.data  = val;
                q.push_back(c);
            end
        end
        return q;
    endfunction

    task automatic build_program();
        prog[0]  = make_ins(OP_LUI,   1, 0, 0, 16'h1234);
        prog[1]  = make_ins(OP_ORI,   1, 1, 0, 16'h5678);
        prog[2]  = make_ins(OP_ADDIU, 2, 0, 0, 16'hfffd);
        prog[3]  = make_ins(OP_ADDU,  3, 1, 2, 0);
        prog[4]  = make_ins(OP_MULTU, 0, 1, 3, 0);
        prog[5]  = make_ins(OP_MFHI,  4, 0, 0, 0);
        prog[6]  = make_ins(OP_MFLO,  5, 0, 0, 0);
        prog[7]  = make_ins(OP_MTHI,  0, 2, 0, 0);
        // both words write hi and the younger one must stick
        prog[8]  = make_ins(OP_MTHI,  0, 1, 0, 0);
        prog[9]  = make_ins(OP_MTHI,  0, 3, 0, 0);
        prog[10] = make_ins(OP_MFHI,  6, 0, 0, 0);
        prog[11] = make_ins(OP_ADDU,  0, 6, 1, 0);
        prog[12] = make_ins(OP_SUBU,  7, 0, 5, 0);
        prog[13] = make_ins(OP_XOR,   7, 7, 3, 0);
        prog[14] = make_ins(OP_MTLO,  0, 4, 0, 0);
        prog[15] = make_ins(OP_MFLO,  1, 0, 0, 0);
        prog[16] = make_ins(OP_NOP,   3, 2, 0, 16'hab01);
        prog[17] = make_ins(OP_AND,   2, 4, 7, 0);
        // random tail with small register numbers so hazards are common
        for (int n = NDIRECTED; n < 2*NPAIRS; n++) begin
            prog[n] = make_ins(op_t'(rand_below(14)), rand_below(8), 1 + rand_below(7),
                               rand_below(8), rand_below(65536));
        end
        for (int p = 0; p < NPAIRS; p++) begin
            mem[p] = {encode(prog[2*p + 1]), encode(prog[2*p])};
        end
    endtask

    // invalid words that carry their own address fill the space past the program
    function automatic logic [63:0] read_pair(word_t adr);
        word_t hi_adr;
        hi_adr = adr + 32'd4;
        if (adr[31:3] < NPAIRS) begin
            return mem[adr[31:3]];
        end
        return {6'h3f, 26'(hi_adr ^ (hi_adr >> 26)), 6'h3f, 26'(adr ^ (adr >> 26))};
    endfunction

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic stop_with_error(input string msg);
        errors++;
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "run aborted");
    endtask

    // Wishbone slave with 0 to 3 wait cycles per request
    always @(posedge clk) begin
        if (!reset) begin
            compare_value("wb stb follows cyc", 64'(wb.cyc), 64'(wb.stb));
            if (wb_ack) begin
                compare_value("wb cyc held through ack", 64'd1, 64'(wb.cyc));
                wb_ack <= 1'b0;
            end else if (wb.cyc && wb.stb) begin
                if (!armed) begin
                    armed      = 1'b1;
                    delay_left = rand_below(4);
                end
                // address holds steady while the slave waits
                compare_value("wb request address", 64'(next_adr), 64'(wb.adr));
                if (delay_left == 0) begin
                    next_adr = next_adr + 32'd8;
                    armed    = 1'b0;
                    wb_ack  <= 1'b1;
                    wb_dat  <= read_pair(wb.adr);
                end else begin
                    delay_left--;
                end
            end else if (armed) begin
                stop_with_error("the core dropped cyc before its request was acknowledged");
            end
        end
    end

    // lane 0 is older than lane 1 within a cycle
    always @(posedge clk) begin
        int idx;
        idx = got;
        if (!reset) begin
            for (int l = 0; l < LANES; l++) begin
                if (commit[l].valid) begin
                    if (idx >= exp_q.size()) begin
                        stop_with_error("the core committed a write the program never makes");
                    end else begin
                        compare_value($sformatf("commit %0d rd", idx),
                                      64'(exp_q[idx].rd), 64'(commit[l].rd));
                        compare_value($sformatf("commit %0d data", idx),
                                      64'(exp_q[idx].data), 64'(commit[l].data));
                        idx++;
                    end
                end
            end
        end
        got <= idx;
    end

    initial begin
        int cycles;
        reset = 1'b1;
        build_program();
        exp_q = run_reference();

        repeat (3) @(posedge clk);
        compare_value("cyc in reset", 64'd0, 64'(wb.cyc));
        compare_value("stb in reset", 64'd0, 64'(wb.stb));
        for (int l = 0; l < LANES; l++) begin
            compare_value($sformatf("commit %0d valid in reset", l), 64'd0,
                          64'(commit[l].valid));
        end
        reset <= 1'b0;

        cycles = 0;
        while (!wb.cyc && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (!wb.cyc) begin
            stop_with_error("the core never opened a fetch request after reset");
        end

        cycles = 0;
        while (got < exp_q.size() && cycles < 5000) begin
            @(posedge clk);
            cycles++;
        end
        if (got < exp_q.size()) begin
            stop_with_error("timed out before all expected register writes were committed");
        end

        // trailing invalid words must not commit anything
        cycles = 0;
        while (cycles < 40) begin
            @(posedge clk);
            cycles++;
        end

        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hw/core_pkg.sv
hw/fetch_unit.sv
hw/issue_unit.sv
hw/reg_file.sv
hw/exec_lane.sv
hw/retire_unit.sv
hw/dual_issue_core.sv
test/tb_core.sv
